// ==== verilog.f ====
source/asg_pkg.sv
source/asg_bus_if.sv
source/asg_rd_if.sv
source/asg_seq.sv
source/asg_table.sv
source/asg_top.sv
testbench/asg_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the signal generator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module asg_tb -f verilog.f -o asg_sim

./obj_dir/asg_sim | tee sim.log

if grep -q "^Test OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// ==== testbench/asg_tb.sv ====
`timescale 1ns/10ps

module asg_tb;

  localparam int ncase = 9;
  localparam int nmax  = 512;

  // one row of the case table
  typedef struct packed {
    logic        ben;
    logic [15:0] siz;
    logic [15:0] stp;
    logic [15:0] off;
    logic [7:0]  bdl;
    logic [15:0] bln;
    logic [7:0]  bnm;
    logic        inf;
    logic [1:0]  trg;
    logic [7:0]  duty;
    logic [15:0] nbt;
  } case_t;

  logic          sto;
  logic          ctl_rst;
  logic [1:0]    trg_in;
  logic [1:0]    cfg_trg;
  logic [15:0]   cfg_siz;
  logic [15:0]   cfg_stp;
  logic [15:0]   cfg_off;
  logic          cfg_ben;
  logic          cfg_inf;
  logic [7:0]    cfg_bdl;
  logic [15:0]   cfg_bln;
  logic [7:0]    cfg_bnm;
  logic          tready;
  logic          bus_wen;
  logic          bus_ren;
  logic [7:0]    bus_addr;
  asg_pkg::dat_t bus_wdata;
  logic          trg_out;
  logic          irq_trg;
  logic          irq_stp;
  asg_pkg::dat_t tdata;
  logic          tvalid;
  logic          tlast;
  asg_pkg::dat_t bus_rdata;
  logic          bus_ack;

  case_t       tbl [ncase];
  string       names [ncase];
  // expected beats as {tlast, data}
  logic [16:0] exp_beat [nmax];
  int          n_exp;
  int          got;
  int          errs;
  int          checks;
  int          n_irq;
  int          n_stp;
  int          n_tout;
  int          duty;
  integer      seed;
  logic [1:0]  trg_now;
  logic [1:0]  cur_trg;
  logic        hold_pend;
  logic [16:0] hold_beat;
  string       cur_name;

  asg_top uut (.*);

  initial begin
    sto = 1'b0;
    forever #5 sto = ~sto;
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // table word built from all address bits
  function automatic asg_pkg::dat_t pattern(input logic [7:0] a);
    return {a ^ 8'h3c, ~a};
  endfunction

  // fixed point step with wrap by siz+1
  function automatic int ptr_step(input int p, input case_t c);
    int q;
    q = p + int'(c.stp) + 1;
    if (q >= int'(c.siz) + 1) begin
      q = q - int'(c.siz) - 1;
    end
    return q;
  endfunction

  task automatic build_expected(input case_t c);
    int p;
    int k;
    int per;
    logic [15:0] last;
    n_exp = 0;
    per = 0;
    p = int'(c.off);
    last = '0;
    while (n_exp < int'(c.nbt)) begin
      if (!c.ben) begin
        exp_beat[n_exp] = {1'b0, pattern(p[15:8])};
        p = ptr_step(p, c);
        n_exp++;
      end else begin
        // every period starts again at the offset
        p = int'(c.off);
        for (k = 0; k <= int'(c.bln) && n_exp < int'(c.nbt); k++) begin
          if (k <= int'(c.bdl)) begin
            last = pattern(p[15:8]);
            p = ptr_step(p, c);
          end
          // hold beats keep last
          exp_beat[n_exp] = {(k == int'(c.bln)) && (per == int'(c.bnm)) && !c.inf, last};
          n_exp++;
        end
        per++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // checks and bus helpers
  //////////////////////////////////////////////////

  task automatic compare(input string what, input logic [31:0] expv,
                         input logic [31:0] actv);
    checks++;
    if (expv !== actv) begin
      errs++;
      $display("[ERROR] %s %s: expected %h, actual %h", cur_name, what, expv, actv);
    end
  endtask

  // one access with ack due on the next edge
  task automatic bus_access(input logic wr, input logic [7:0] a);
    @(posedge sto);
    #1;
    bus_wen   = wr;
    bus_ren   = !wr;
    bus_addr  = a;
    bus_wdata = pattern(a);
    @(posedge sto);
    #1;
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    compare("bus ack", 32'(1), 32'(bus_ack));
    if (!wr) begin
      compare("read back", 32'(pattern(a)), 32'(bus_rdata));
    end
  endtask

  task automatic reset_dut();
    @(posedge sto);
    #1;
    ctl_rst = 1'b1;
    repeat (2) @(posedge sto);
    #1;
    ctl_rst   = 1'b0;
    hold_pend = 1'b0;
    compare("reset outputs", 32'(0), 32'({tvalid, tlast, trg_out, irq_trg, irq_stp, bus_ack}));
  endtask

  //////////////////////////////////////////////////
  // stream side
  //////////////////////////////////////////////////

  // drive after the edge and sample at negedge
  task automatic step_cycle();
    @(posedge sto);
    #1;
    trg_in  = trg_now;
    trg_now = '0;
    tready  = ($unsigned($random(seed)) % 100) < duty;
    @(negedge sto);
    // beat stalled last cycle must not move
    if (hold_pend) begin
      compare("held tvalid", 32'(1), 32'(tvalid));
      compare("held beat", 32'(hold_beat), 32'({tlast, tdata}));
    end
    hold_pend = tvalid && !tready;
    hold_beat = {tlast, tdata};
    n_irq  += int'(irq_trg);
    n_stp  += int'(irq_stp);
    n_tout += int'(trg_out);
    if (tvalid && tready) begin
      if (got < n_exp) begin
        compare("beat", 32'(exp_beat[got]), 32'({tlast, tdata}));
      end else begin
        errs++;
        $display("%s: beat %0d arrived after the end of the sequence", cur_name, got);
      end
      got++;
    end
  endtask

  task automatic collect_beats(input int want);
    int cyc;
    cyc = 0;
    while (got < want && cyc < want * 4 + 50) begin
      // retrigger while running is ignored
      if (got == 5) begin
        trg_now = cur_trg;
      end
      step_cycle();
      cyc++;
    end
    if (got < want) begin
      errs++;
      $display("%s: timeout, %0d of %0d beats received", cur_name, got, want);
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int i;
    int a;
    int errs0;
    case_t c;
    seed      = 32'hd705_96b1;
    ctl_rst   = 1'b1;
    trg_in    = '0;
    cfg_trg   = 2'b01;
    cfg_siz   = '0;
    cfg_stp   = '0;
    cfg_off   = '0;
    cfg_ben   = 1'b0;
    cfg_inf   = 1'b0;
    cfg_bdl   = '0;
    cfg_bln   = '0;
    cfg_bnm   = '0;
    tready    = 1'b1;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    errs      = 0;
    checks    = 0;
    duty      = 100;
    trg_now   = '0;
    hold_pend = 1'b0;

    // ben siz stp off bdl bln bnm inf trg duty nbt
    names[0] = "per_unit";
    tbl[0] = '{1'b0, 16'hffff, 16'h00ff, 16'h0000, 8'd0, 16'd0, 8'd0, 1'b0, 2'b01, 8'd100, 16'd300};
    names[1] = "per_frac";
    tbl[1] = '{1'b0, 16'h63ff, 16'h00bf, 16'h1080, 8'd0, 16'd0, 8'd0, 1'b0, 2'b01, 8'd100, 16'd200};
    names[2] = "per_off";
    tbl[2] = '{1'b0, 16'h1fff, 16'h02ff, 16'h0a00, 8'd0, 16'd0, 8'd0, 1'b0, 2'b01, 8'd100, 16'd80};
    names[3] = "burst";
    tbl[3] = '{1'b1, 16'hffff, 16'h00ff, 16'h0500, 8'd3, 16'd7, 8'd2, 1'b0, 2'b01, 8'd100, 16'd24};
    names[4] = "burst_frac";
    tbl[4] = '{1'b1, 16'h07ff, 16'h017f, 16'h0300, 8'd5, 16'd5, 8'd1, 1'b0, 2'b01, 8'd100, 16'd12};
    names[5] = "per_frac_bp";
    tbl[5] = '{1'b0, 16'h63ff, 16'h00bf, 16'h1080, 8'd0, 16'd0, 8'd0, 1'b0, 2'b01, 8'd50, 16'd200};
    names[6] = "burst_bp";
    tbl[6] = '{1'b1, 16'hffff, 16'h00ff, 16'h0500, 8'd3, 16'd7, 8'd2, 1'b0, 2'b01, 8'd40, 16'd24};
    names[7] = "masked_trg";
    tbl[7] = '{1'b0, 16'hffff, 16'h00ff, 16'h0000, 8'd0, 16'd0, 8'd0, 1'b0, 2'b10, 8'd100, 16'd0};
    names[8] = "reset_abort";
    tbl[8] = '{1'b1, 16'hffff, 16'h00ff, 16'h2000, 8'd2, 16'd4, 8'd0, 1'b1, 2'b01, 8'd100, 16'd12};

    cur_name = "cpu_table";
    reset_dut();
    for (a = 0; a < 256; a++) begin
      bus_access(1'b1, a[7:0]);
    end
    for (a = 0; a < 256; a++) begin
      bus_access(1'b0, a[7:0]);
    end
    $display("case %-12s done, %0d errors", cur_name, errs);

    for (i = 0; i < ncase; i++) begin
      c        = tbl[i];
      cur_name = names[i];
      errs0    = errs;
      @(posedge sto);
      #1;
      cfg_ben  = c.ben;
      cfg_inf  = c.inf;
      cfg_siz  = c.siz;
      cfg_stp  = c.stp;
      cfg_off  = c.off;
      cfg_bdl  = c.bdl;
      cfg_bln  = c.bln;
      cfg_bnm  = c.bnm;
      cur_trg  = c.trg;
      duty     = int'(c.duty);
      reset_dut();
      got    = 0;
      n_irq  = 0;
      n_stp  = 0;
      n_tout = 0;
      build_expected(c);
      trg_now = c.trg;
      collect_beats(n_exp);
      if (c.inf) begin
        // abort the endless burst and then start over
        @(posedge sto);
        #1;
        ctl_rst = 1'b1;
        @(posedge sto);
        #1;
        ctl_rst = 1'b0;
        compare("abort outputs", 32'(0), 32'({tvalid, tlast, trg_out}));
        got       = 0;
        hold_pend = 1'b0;
        trg_now   = c.trg;
        collect_beats(n_exp);
      end else if (c.ben || n_exp == 0) begin
        // stream stays quiet after the end
        repeat (16) step_cycle();
        compare("beat count", 32'(n_exp), 32'(got));
        compare("tvalid after end", 32'(0), 32'(tvalid));
        compare("irq_trg count", 32'(n_exp == 0 ? 0 : int'(c.bnm) + 1), 32'(n_irq));
        compare("irq_stp count", 32'(n_exp == 0 ? 0 : 1), 32'(n_stp));
        compare("trg_out count", 32'(n_exp == 0 ? 0 : int'(c.bnm) + 1), 32'(n_tout));
      end else begin
        compare("irq_trg count", 32'(1), 32'(n_irq));
        compare("trg_out count", 32'(1), 32'(n_tout));
      end
      $display("case %-12s %0d beats, %0d errors", cur_name, got, errs - errs0);
    end

    $display("%0d cases, %0d checks, %0d errors", ncase + 1, checks, errs);
    if (errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== source/asg_top.sv ====
`timescale 1ns/10ps

module asg_top #(
  int unsigned cwm = asg_pkg::def_cwm,
  int unsigned cwf = asg_pkg::def_cwf,
  int unsigned cwl = asg_pkg::def_cwl,
  int unsigned cwn = asg_pkg::def_cwn,
  int unsigned tn  = asg_pkg::def_tn
) (
  input  logic               sto,
  input  logic               ctl_rst,
  // trigger
  input  logic [tn-1:0]      trg_in,
  output logic               trg_out,
  // interrupts
  output logic               irq_trg,
  output logic               irq_stp,
  // periodic setup
  input  logic [tn-1:0]      cfg_trg,
  input  logic [cwm+cwf-1:0] cfg_siz,
  input  logic [cwm+cwf-1:0] cfg_stp,
  input  logic [cwm+cwf-1:0] cfg_off,
  // burst setup
  input  logic               cfg_ben,
  input  logic               cfg_inf,
  input  logic [cwm-1:0]     cfg_bdl,
  input  logic [cwl-1:0]     cfg_bln,
  input  logic [cwn-1:0]     cfg_bnm,
  // DAC stream
  output asg_pkg::dat_t      tdata,
  output logic               tvalid,
  input  logic               tready,
  output logic               tlast,
  // CPU table bus
  input  logic               bus_wen,
  input  logic               bus_ren,
  input  logic [cwm-1:0]     bus_addr,
  input  asg_pkg::dat_t      bus_wdata,
  output asg_pkg::dat_t      bus_rdata,
  output logic               bus_ack
);

  asg_bus_if #(.cwm(cwm)) bus ();
  asg_rd_if  #(.cwm(cwm)) rd ();

  //////////////////////////////////////////////////
  // CPU bus onto the interface
  //////////////////////////////////////////////////

  assign bus.wen   = bus_wen;
  assign bus.ren   = bus_ren;
  assign bus.addr  = bus_addr;
  assign bus.wdata = bus_wdata;
  assign bus_rdata = bus.rdata;
  assign bus_ack   = bus.ack;

  //////////////////////////////////////////////////
  // sequencer and table
  //////////////////////////////////////////////////

  asg_seq #(
    .cwm (cwm),
    .cwf (cwf),
    .cwl (cwl),
    .cwn (cwn),
    .tn  (tn)
  ) u_seq (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .trg_in  (trg_in),
    .cfg_trg (cfg_trg),
    .trg_out (trg_out),
    .irq_trg (irq_trg),
    .irq_stp (irq_stp),
    .cfg_siz (cfg_siz),
    .cfg_stp (cfg_stp),
    .cfg_off (cfg_off),
    .cfg_ben (cfg_ben),
    .cfg_inf (cfg_inf),
    .cfg_bdl (cfg_bdl),
    .cfg_bln (cfg_bln),
    .cfg_bnm (cfg_bnm),
    .rd      (rd.seq)
  );

  // memory plus output stage
  asg_table #(
    .cwm (cwm)
  ) u_table (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .tready  (tready),
    .tdata   (tdata),
    .tvalid  (tvalid),
    .tlast   (tlast),
    .bus     (bus.tbl),
    .rd      (rd.tbl)
  );

endmodule

// ==== source/asg_table.sv ====
`timescale 1ns/10ps

module asg_table #(
  int unsigned cwm = asg_pkg::def_cwm
) (
  input  logic          sto,
  input  logic          ctl_rst,
  // stream
  input  logic          tready,
  output asg_pkg::dat_t tdata,
  output logic          tvalid,
  output logic          tlast,
  // CPU access
  asg_bus_if.tbl        bus,
  // sequencer
  asg_rd_if.tbl         rd
);

  typedef logic [cwm-1:0] adr_t;

  // sample memory
  asg_pkg::dat_t mem [0:2**cwm-1];

  // first read stage
  adr_t adr_r;
  logic vld_r;
  logic ren_r;
  logic lst_r;

  //////////////////////////////////////////////////
  // CPU port
  //////////////////////////////////////////////////

  // write and read-back, rdy not involved
  always_ff @(posedge sto) begin
    if (bus.wen) begin
      mem[bus.addr] <= bus.wdata;
    end
    if (bus.ren) begin
      bus.rdata <= mem[bus.addr];
    end
  end

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= bus.wen || bus.ren;
    end
  end

  //////////////////////////////////////////////////
  // stream read pipeline
  //////////////////////////////////////////////////

  // free slot or beat leaving this cycle
  assign rd.rdy = tready || !tvalid;

  // address and data registers
  always_ff @(posedge sto) begin
    if (rd.rdy) begin
      if (rd.aen) begin
        adr_r <= rd.raddr;
      end
      // hold beats keep the last sample
      if (ren_r) begin
        tdata <= mem[adr_r];
      end
    end
  end

  // flags ride along with the address, then the data
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      vld_r  <= 1'b0;
      ren_r  <= 1'b0;
      lst_r  <= 1'b0;
      tvalid <= 1'b0;
      tlast  <= 1'b0;
    end else if (rd.rdy) begin
      vld_r  <= rd.run;
      ren_r  <= rd.aen;
      lst_r  <= rd.lst;
      tvalid <= vld_r;
      tlast  <= lst_r;
    end
  end

endmodule

// ==== source/asg_seq.sv ====
`timescale 1ns/10ps

module asg_seq #(
  int unsigned cwm = asg_pkg::def_cwm,
  int unsigned cwf = asg_pkg::def_cwf,
  int unsigned cwl = asg_pkg::def_cwl,
  int unsigned cwn = asg_pkg::def_cwn,
  int unsigned tn  = asg_pkg::def_tn
) (
  input  logic               sto,
  input  logic               ctl_rst,
  // trigger
  input  logic [tn-1:0]      trg_in,
  input  logic [tn-1:0]      cfg_trg,
  output logic               trg_out,
  // interrupts
  output logic               irq_trg,
  output logic               irq_stp,
  // periodic setup, fixed point
  input  logic [cwm+cwf-1:0] cfg_siz,
  input  logic [cwm+cwf-1:0] cfg_stp,
  input  logic [cwm+cwf-1:0] cfg_off,
  // burst setup
  input  logic               cfg_ben,
  input  logic               cfg_inf,
  input  logic [cwm-1:0]     cfg_bdl,
  input  logic [cwl-1:0]     cfg_bln,
  input  logic [cwn-1:0]     cfg_bnm,
  // toward the table
  asg_rd_if.seq              rd
);

  // pointer width and common width for beat compare
  localparam int unsigned cw  = cwm + cwf;
  localparam int unsigned cwb = (cwl > cwm) ? cwl : cwm;

  typedef logic [cw-1:0]  ptr_t;
  typedef logic [cw:0]    ptr_ext_t;
  typedef logic [cwb-1:0] beat_t;
  typedef logic [cwl-1:0] bln_t;
  typedef logic [cwn-1:0] rep_t;

  asg_pkg::seq_state_t state;

  // read pointer
  ptr_t     ptr;
  ptr_ext_t ptr_nxt;
  ptr_ext_t ptr_sub;
  ptr_t     ptr_adv;

  // burst counters
  bln_t cnt_bln;
  rep_t cnt_bnm;

  logic trg_acc;
  logic burst;
  logic end_bdl;
  logic end_bln;
  logic end_bnm;
  logic per_end;
  logic evt_str;
  logic evt_rpt;
  logic evt_trg;

  //////////////////////////////////////////////////
  // status and events
  //////////////////////////////////////////////////

  // masked trigger
  assign trg_acc = |(trg_in & cfg_trg);

  assign burst   = (state == asg_pkg::st_bdat) || (state == asg_pkg::st_bgap);
  // last table beat of the period
  assign end_bdl = beat_t'(cnt_bln) == beat_t'(cfg_bdl);
  assign end_bln = cnt_bln == cfg_bln;
  // infinite run never reaches the final burst
  assign end_bnm = (cnt_bnm == cfg_bnm) && !cfg_inf;
  assign per_end = burst && end_bln;

  // start from idle, restart at period end
  assign evt_str = rd.rdy && (state == asg_pkg::st_idle) && trg_acc;
  assign evt_rpt = rd.rdy && per_end && !end_bnm;
  assign evt_trg = evt_str || evt_rpt;

  //////////////////////////////////////////////////
  // state machine and burst counters
  //////////////////////////////////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state   <= asg_pkg::st_idle;
      cnt_bln <= '0;
      cnt_bnm <= '0;
    end else if (rd.rdy) begin
      case (state)
        asg_pkg::st_idle: begin
          // triggers count only here
          if (trg_acc) begin
            state   <= cfg_ben ? asg_pkg::st_bdat : asg_pkg::st_per;
            cnt_bln <= '0;
            cnt_bnm <= '0;
          end
        end
        asg_pkg::st_bdat, asg_pkg::st_bgap: begin
          if (end_bln) begin
            // period done, restart or stop
            cnt_bln <= '0;
            cnt_bnm <= cnt_bnm + rep_t'(1);
            state   <= end_bnm ? asg_pkg::st_idle : asg_pkg::st_bdat;
          end else begin
            cnt_bln <= cnt_bln + bln_t'(1);
            // switch to hold beats after the last table beat
            if ((state == asg_pkg::st_bdat) && end_bdl) begin
              state <= asg_pkg::st_bgap;
            end
          end
        end
        // periodic run holds until reset
        default: state <= state;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // fixed point read pointer
  //////////////////////////////////////////////////

  // step, then take one table length off
  assign ptr_nxt = {1'b0, ptr} + {1'b0, cfg_stp} + ptr_ext_t'(1);
  assign ptr_sub = ptr_nxt - ({1'b0, cfg_siz} + ptr_ext_t'(1));
  // negative difference means no wrap yet
  assign ptr_adv = ptr_sub[cw] ? ptr_nxt[cw-1:0] : ptr_sub[cw-1:0];

  always_ff @(posedge sto) begin
    if (rd.rdy) begin
      // offset sets the phase on every start
      if (evt_trg) begin
        ptr <= cfg_off;
      end else if (rd.aen) begin
        ptr <= ptr_adv;
      end
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  assign rd.run   = state != asg_pkg::st_idle;
  // hold beats keep the address
  assign rd.aen   = (state == asg_pkg::st_per) || (state == asg_pkg::st_bdat);
  assign rd.lst   = per_end && end_bnm;
  assign rd.raddr = ptr[cwf +: cwm];

  assign irq_trg = evt_trg;
  // last beat accepted into the pipeline
  assign irq_stp = rd.lst && rd.rdy;

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      trg_out <= 1'b0;
    end else begin
      trg_out <= evt_trg;
    end
  end

endmodule

// ==== source/asg_rd_if.sv ====
`timescale 1ns/10ps

interface asg_rd_if #(
  int unsigned cwm = asg_pkg::def_cwm
);

  // pointer advancing, table read wanted
  logic           aen;
  // beat to be produced
  logic           run;
  // beat closes the final burst
  logic           lst;
  // integer part of pointer
  logic [cwm-1:0] raddr;
  // output register can take a beat
  logic           rdy;

  // sequencer side
  modport seq (
    output aen, run, lst, raddr,
    input  rdy
  );

  // table side
  // rdy comes back from the output stage
  modport tbl (
    input  aen, run, lst, raddr,
    output rdy
  );

endinterface

// ==== source/asg_bus_if.sv ====
`timescale 1ns/10ps

interface asg_bus_if #(
  int unsigned cwm = asg_pkg::def_cwm
);

  // access strobes
  logic           wen;
  logic           ren;
  // table word address
  logic [cwm-1:0] addr;
  asg_pkg::dat_t  wdata;
  asg_pkg::dat_t  rdata;
  // one cycle after each strobe
  logic           ack;

  // CPU side
  modport master (
    output wen, ren, addr, wdata,
    input  rdata, ack
  );

  // sample table side
  modport tbl (
    input  wen, ren, addr, wdata,
    output rdata, ack
  );

endinterface

// ==== source/asg_pkg.sv ====
package asg_pkg;

  //////////////////////////////////////////////////
  // sample format
  //////////////////////////////////////////////////

  // one DAC sample in two's complement
  // same word in table, stream and bus data lines
  typedef logic signed [15:0] dat_t;

  //////////////////////////////////////////////////
  // sequencer states
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // waiting for trigger
    st_idle,
    // periodic run
    st_per,
    // burst table beats
    st_bdat,
    // burst hold beats
    st_bgap
  } seq_state_t;

  //////////////////////////////////////////////////
  // default widths
  //////////////////////////////////////////////////

  // pointer integer bits, table depth is 2**def_cwm
  localparam int unsigned def_cwm = 8;
  // pointer fraction bits
  localparam int unsigned def_cwf = 8;
  // burst period counter
  localparam int unsigned def_cwl = 16;
  // burst repetition counter
  localparam int unsigned def_cwn = 8;
  // trigger inputs
  localparam int unsigned def_tn  = 2;

endpackage
